/* logic/cam_pkg.sv */
// Geometry of the victim buffer; the depth must stay a power of two so slot indices wrap freely

package cam_pkg;

    // ************************************************************
    // buffer geometry
    // ************************************************************
    localparam int cam_depth  = 16;
    localparam int slot_bits  = 4;
    localparam int count_bits = 5;   // one more bit than a slot so a full buffer counts 16

    typedef logic [slot_bits-1:0]  slot_t;
    typedef logic [count_bits-1:0] count_t;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_insert,
        st_clear,
        st_scan,
        st_resolve,
        st_memreq,
        st_done
    } cam_state_e;

endpackage

/* logic/req_pkg.sv */
// Request and response formats seen by the FIFOs around the buffer; needs cam_pkg compiled first

package req_pkg;

    // ************************************************************
    // traffic fields
    // ************************************************************
    typedef logic [25:0] line_addr_t;
    typedef logic [7:0]  seq_t;

    // request as it arrives on the insert and lookup FIFOs
    // and as it leaves toward the memory request queue
    typedef struct packed {
        seq_t       seq;
        line_addr_t addr;
        logic       wr;
    } mem_req_t;

    // lookup result
    // slot is only meaningful when miss is low
    typedef struct packed {
        seq_t           seq;
        logic           miss;
        cam_pkg::slot_t slot;
    } vpkt_t;

endpackage

/* logic/cam_occupancy.sv */
// Circular pointers over the buffer slots; the controller never raises both go signals together
`timescale 1ns/1ns

module cam_occupancy (
    input  logic            clk,
    input  logic            rst,
    input  logic            ins_go,
    input  logic            clr_go,
    output cam_pkg::slot_t  wr_slot,
    output cam_pkg::slot_t  rd_slot,
    output cam_pkg::count_t count
);

    // ************************************************************
    // write side grows the queue, release side shrinks it
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_slot <= '0;
            rd_slot <= '0;
            count   <= '0;
        end else if (ins_go) begin
            // slot index wraps on its own since the depth is a power of two
            wr_slot <= wr_slot + cam_pkg::slot_t'(1);
            count   <= count + cam_pkg::count_t'(1);
        end else if (clr_go) begin
            // oldest entry leaves first
            rd_slot <= rd_slot + cam_pkg::slot_t'(1);
            count   <= count - cam_pkg::count_t'(1);
        end
    end

endmodule

/* logic/cam_scan_counter.sv */
// Walks occupied slots oldest to newest; count must not change while a scan runs
`timescale 1ns/1ns

module cam_scan_counter (
    input  logic            clk,
    input  logic            rst,
    input  logic            scan_start,
    input  cam_pkg::slot_t  rd_slot,
    input  cam_pkg::count_t count,
    output cam_pkg::slot_t  scan_addr,
    output logic            scan_valid,
    output logic            scan_last
);

    // slots still to visit, including the current one
    cam_pkg::count_t left;

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_valid <= 1'b0;
            left       <= '0;
        end else if (scan_start) begin
            scan_valid <= (count != '0);
            left       <= count;
        end else if (scan_valid) begin
            if (left == cam_pkg::count_t'(1)) begin
                scan_valid <= 1'b0;
            end
            left <= left - cam_pkg::count_t'(1);
        end
    end

    // one slot per cycle from the oldest entry, wrapping at the depth
    always_ff @(posedge clk) begin
        if (scan_start) begin
            scan_addr <= rd_slot;
        end else if (scan_valid) begin
            scan_addr <= scan_addr + cam_pkg::slot_t'(1);
        end
    end

    assign scan_last = scan_valid && (left == cam_pkg::count_t'(1));

endmodule

/* logic/cam_entry_ram.sv */
// Simple dual-port address store; reads return the old word when read and write hit one slot
`timescale 1ns/1ns

module cam_entry_ram (
    input  logic                clk,
    input  logic                wr_en,
    input  cam_pkg::slot_t      wr_slot,
    input  req_pkg::line_addr_t wr_addr_data,
    input  cam_pkg::slot_t      rd_slot,
    output req_pkg::line_addr_t rd_data
);

    req_pkg::line_addr_t mem [cam_pkg::cam_depth];

    // power-up contents are zero
    initial begin
        for (int i = 0; i < cam_pkg::cam_depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_slot] <= wr_addr_data;
        end
    end

    // one-cycle registered read
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_slot];
    end

endmodule

/* logic/cam_match_unit.sv */
// Compares scanned entries against the lookup head; result is valid two cycles after the last address
`timescale 1ns/1ns

module cam_match_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                scan_start,
    input  logic                scan_valid,
    input  cam_pkg::slot_t      scan_addr,
    input  req_pkg::line_addr_t rd_data,
    input  req_pkg::mem_req_t   lookup_head,
    output logic                hit,
    output cam_pkg::slot_t      hit_slot
);

    logic           valid_d;
    cam_pkg::slot_t slot_d;

    // line valid and index up with the registered RAM output
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= scan_valid;
        end
        slot_d <= scan_addr;
    end

    // ************************************************************
    // newest copy wins
    // ************************************************************
    // scan runs oldest to newest so every later match overwrites the earlier one
    always_ff @(posedge clk) begin
        if (rst || scan_start) begin
            hit      <= 1'b0;
            hit_slot <= '0;
        end else if (valid_d && (rd_data == lookup_head.addr)) begin
            hit      <= 1'b1;
            hit_slot <= slot_d;
        end
    end

endmodule

/* logic/cam_ctrl_fsm.sv */
// Serves one request at a time and assumes sequence numbers never wrap within a run
`timescale 1ns/1ns

module cam_ctrl_fsm (
    input  logic              clk,
    input  logic              rst,
    input  req_pkg::mem_req_t insert_head,
    input  logic              insert_empty,
    input  req_pkg::mem_req_t lookup_head,
    input  logic              lookup_empty,
    input  logic              clear_empty,
    input  logic              vpkt_full,
    input  logic              mem_req_full,
    input  cam_pkg::count_t   count,
    input  logic              scan_last,
    input  logic              hit,
    input  cam_pkg::slot_t    hit_slot,
    output logic              insert_pop,
    output logic              clear_pop,
    output logic              lookup_pop,
    output logic              vpkt_wr,
    output logic              mem_req_wr,
    output logic              ins_go,
    output logic              clr_go,
    output logic              scan_start,
    output req_pkg::vpkt_t    vpkt,
    output req_pkg::mem_req_t mem_req
);

    cam_pkg::cam_state_e state;
    cam_pkg::cam_state_e state_nxt;

    logic buf_empty;
    logic buf_full;
    logic lookup_first;
    logic pick_lookup;
    logic pick_insert;
    logic pick_clear;
    logic send_miss;
    logic send_hit;
    logic scan_last_q;

    assign buf_empty = (count == '0);
    assign buf_full  = (count == cam_pkg::count_t'(cam_pkg::cam_depth));

    // ************************************************************
    // arbitration
    // ************************************************************
    // lookup wins ties: an instruction that both looks up and evicts
    // must search before its own victim is in the buffer
    assign lookup_first = !lookup_empty &&
                          (insert_empty || (lookup_head.seq <= insert_head.seq));

    // a lookup that is due but blocked downstream also holds back the insert
    assign pick_lookup = lookup_first && !vpkt_full && !mem_req_full;
    assign pick_insert = !insert_empty && !lookup_first && !buf_full;
    // nothing to release in an empty buffer
    assign pick_clear  = !pick_lookup && !pick_insert && !clear_empty && !buf_empty;

    // result of the current lookup
    assign send_miss = ((state == cam_pkg::st_idle) && pick_lookup && buf_empty) ||
                       ((state == cam_pkg::st_resolve) && !hit);
    assign send_hit  = (state == cam_pkg::st_resolve) && hit;

    // ************************************************************
    // next state
    // ************************************************************
    always_comb begin
        state_nxt = state;
        case (state)
            cam_pkg::st_idle: begin
                if (pick_insert) begin
                    state_nxt = cam_pkg::st_insert;
                end else if (pick_clear) begin
                    state_nxt = cam_pkg::st_clear;
                end else if (pick_lookup) begin
                    state_nxt = buf_empty ? cam_pkg::st_memreq : cam_pkg::st_scan;
                end
            end
            cam_pkg::st_insert:  state_nxt = cam_pkg::st_done;
            cam_pkg::st_clear:   state_nxt = cam_pkg::st_done;
            cam_pkg::st_scan: begin
                // the RAM read and the compare trail the last address by two cycles
                if (scan_last_q) begin
                    state_nxt = cam_pkg::st_resolve;
                end
            end
            cam_pkg::st_resolve: begin
                state_nxt = hit ? cam_pkg::st_done : cam_pkg::st_memreq;
            end
            cam_pkg::st_memreq:  state_nxt = cam_pkg::st_done;
            cam_pkg::st_done:    state_nxt = cam_pkg::st_idle;
            default:             state_nxt = cam_pkg::st_idle;
        endcase
    end

    // ************************************************************
    // state and registered strobes
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= cam_pkg::st_idle;
            insert_pop  <= 1'b0;
            clear_pop   <= 1'b0;
            lookup_pop  <= 1'b0;
            vpkt_wr     <= 1'b0;
            mem_req_wr  <= 1'b0;
            scan_start  <= 1'b0;
            scan_last_q <= 1'b0;
        end else begin
            state       <= state_nxt;
            insert_pop  <= (state == cam_pkg::st_idle) && pick_insert;
            clear_pop   <= (state == cam_pkg::st_idle) && pick_clear;
            scan_start  <= (state == cam_pkg::st_idle) && pick_lookup && !buf_empty;
            lookup_pop  <= send_miss || send_hit;
            vpkt_wr     <= send_miss || send_hit;
            mem_req_wr  <= send_miss;
            scan_last_q <= scan_last;
        end
    end

    // pointer updates land in the same cycle as the pops
    assign ins_go = insert_pop;
    assign clr_go = clear_pop;

    // outgoing packets, qualified by the write strobes
    always_ff @(posedge clk) begin
        if (send_miss || send_hit) begin
            vpkt.seq  <= lookup_head.seq;
            vpkt.miss <= send_miss;
            vpkt.slot <= send_hit ? hit_slot : '0;
        end
        if (send_miss) begin
            mem_req <= lookup_head;
        end
    end

endmodule

/* logic/victim_cam_top.sv */
// Victim address buffer with FIFO handshakes on all sides; upstream heads must stay stable until popped
`timescale 1ns/1ns

module victim_cam_top (
    input  logic              clk,
    input  logic              rst,
    // insert request FIFO
    input  req_pkg::mem_req_t insert_head,
    input  logic              insert_empty,
    output logic              insert_pop,
    // clear FIFO, no payload
    input  logic              clear_empty,
    output logic              clear_pop,
    // lookup request FIFO
    input  req_pkg::mem_req_t lookup_head,
    input  logic              lookup_empty,
    output logic              lookup_pop,
    // victim packet FIFO
    output req_pkg::vpkt_t    vpkt,
    output logic              vpkt_wr,
    input  logic              vpkt_full,
    // memory request FIFO
    output req_pkg::mem_req_t mem_req,
    output logic              mem_req_wr,
    input  logic              mem_req_full
);

    logic                  ins_go;
    logic                  clr_go;
    logic                  scan_start;
    cam_pkg::count_t       count;
    cam_pkg::slot_t        wr_slot;
    cam_pkg::slot_t        rd_slot;
    cam_pkg::slot_t        scan_addr;
    logic                  scan_valid;
    logic                  scan_last;
    req_pkg::line_addr_t   ram_data;
    logic                  hit;
    cam_pkg::slot_t        hit_slot;

    cam_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .insert_head  (insert_head),
        .insert_empty (insert_empty),
        .lookup_head  (lookup_head),
        .lookup_empty (lookup_empty),
        .clear_empty  (clear_empty),
        .vpkt_full    (vpkt_full),
        .mem_req_full (mem_req_full),
        .count        (count),
        .scan_last    (scan_last),
        .hit          (hit),
        .hit_slot     (hit_slot),
        .insert_pop   (insert_pop),
        .clear_pop    (clear_pop),
        .lookup_pop   (lookup_pop),
        .vpkt_wr      (vpkt_wr),
        .mem_req_wr   (mem_req_wr),
        .ins_go       (ins_go),
        .clr_go       (clr_go),
        .scan_start   (scan_start),
        .vpkt         (vpkt),
        .mem_req      (mem_req)
    );

    cam_occupancy u_occ (
        .clk     (clk),
        .rst     (rst),
        .ins_go  (ins_go),
        .clr_go  (clr_go),
        .wr_slot (wr_slot),
        .rd_slot (rd_slot),
        .count   (count)
    );

    cam_scan_counter u_scan (
        .clk        (clk),
        .rst        (rst),
        .scan_start (scan_start),
        .rd_slot    (rd_slot),
        .count      (count),
        .scan_addr  (scan_addr),
        .scan_valid (scan_valid),
        .scan_last  (scan_last)
    );

    // insert head is still valid during the pop cycle, which is when the write lands
    cam_entry_ram u_ram (
        .clk          (clk),
        .wr_en        (ins_go),
        .wr_slot      (wr_slot),
        .wr_addr_data (insert_head.addr),
        .rd_slot      (scan_addr),
        .rd_data      (ram_data)
    );

    cam_match_unit u_match (
        .clk         (clk),
        .rst         (rst),
        .scan_start  (scan_start),
        .scan_valid  (scan_valid),
        .scan_addr   (scan_addr),
        .rd_data     (ram_data),
        .lookup_head (lookup_head),
        .hit         (hit),
        .hit_slot    (hit_slot)
    );

endmodule

/* verif/tb_clock_gen.sv */
// Free-running 4 ns clock with a synchronous active-high reset held for the first 5 cycles
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset drops just after an edge so it never races the DUT registers
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* verif/victim_cam_assert.sv */
// Protocol assertions bound into the controller; count is seen on the controller's count input
`timescale 1ns/1ns

module victim_cam_assert (
    input logic            clk,
    input logic            rst,
    input logic            insert_pop,
    input logic            clear_pop,
    input logic            lookup_pop,
    input logic            vpkt_wr,
    input logic            mem_req_wr,
    input logic            mem_req_full,
    input logic            clr_go,
    input cam_pkg::count_t count
);

    // failed assertions so far
    int fail_count;

    initial begin
        fail_count = 0;
    end

    // ************************************************************
    // single-cycle strobes
    // ************************************************************
    a_insert_pulse: assert property (@(posedge clk) disable iff (rst) insert_pop |=> !insert_pop)
        else begin
            $error("insert_pop held longer than one cycle");
            fail_count++;
        end
    a_clear_pulse: assert property (@(posedge clk) disable iff (rst) clear_pop |=> !clear_pop)
        else begin
            $error("clear_pop held longer than one cycle");
            fail_count++;
        end
    a_lookup_pulse: assert property (@(posedge clk) disable iff (rst) lookup_pop |=> !lookup_pop)
        else begin
            $error("lookup_pop held longer than one cycle");
            fail_count++;
        end
    a_vpkt_pulse: assert property (@(posedge clk) disable iff (rst) vpkt_wr |=> !vpkt_wr)
        else begin
            $error("vpkt_wr held longer than one cycle");
            fail_count++;
        end
    a_memreq_pulse: assert property (@(posedge clk) disable iff (rst) mem_req_wr |=> !mem_req_wr)
        else begin
            $error("mem_req_wr held longer than one cycle");
            fail_count++;
        end

    // ************************************************************
    // occupancy and back-pressure
    // ************************************************************
    // an underflow would wrap past 16 as well
    a_count_max: assert property (@(posedge clk) disable iff (rst)
        count <= cam_pkg::count_t'(cam_pkg::cam_depth))
        else begin
            $error("entry count out of range");
            fail_count++;
        end
    a_no_empty_clear: assert property (@(posedge clk) disable iff (rst) clr_go |-> count != '0)
        else begin
            $error("release from an empty buffer");
            fail_count++;
        end
    a_memreq_full: assert property (@(posedge clk) disable iff (rst) !(mem_req_wr && mem_req_full))
        else begin
            $error("mem_req_wr while the memory request FIFO is full");
            fail_count++;
        end

endmodule

bind cam_ctrl_fsm victim_cam_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .insert_pop   (insert_pop),
    .clear_pop    (clear_pop),
    .lookup_pop   (lookup_pop),
    .vpkt_wr      (vpkt_wr),
    .mem_req_wr   (mem_req_wr),
    .mem_req_full (mem_req_full),
    .clr_go       (clr_go),
    .count        (count)
);

/* verif/victim_cam_tb.sv */
// Operation table run in order; rows marked batch are pushed in the same cycle as the next row
`timescale 1ns/1ns

module victim_cam_tb;

    typedef enum logic [1:0] {op_insert, op_clear, op_lookup} op_e;

    typedef struct {
        op_e                 kind;
        req_pkg::line_addr_t addr;
        req_pkg::seq_t       seq;
        int                  hold;   // cycles of mem_req_full before the lookup may go
        bit                  batch;  // do not wait for completion before the next row
    } row_t;

    logic              clk;
    logic              rst;
    req_pkg::mem_req_t insert_head;
    logic              insert_empty;
    logic              insert_pop;
    logic              clear_empty;
    logic              clear_pop;
    req_pkg::mem_req_t lookup_head;
    logic              lookup_empty;
    logic              lookup_pop;
    req_pkg::vpkt_t    vpkt;
    logic              vpkt_wr;
    logic              vpkt_full;
    req_pkg::mem_req_t mem_req;
    logic              mem_req_wr;
    logic              mem_req_full;

    // upstream FIFO contents and pops seen in the previous cycle
    req_pkg::mem_req_t ins_q[$];
    req_pkg::mem_req_t lk_q[$];
    int                clr_cnt;
    logic              pend_ins;
    logic              pend_clr;
    logic              pend_lk;

    // reference model of the buffer and the expected outputs
    int                  ref_slot[$];
    req_pkg::line_addr_t ref_addr[$];
    int                  next_slot;
    req_pkg::vpkt_t      exp_vpkt[$];
    req_pkg::mem_req_t   exp_mem[$];

    row_t                table_q[$];
    req_pkg::line_addr_t pool[20];
    integer              seed;
    int                  value_errors;
    int                  other_errors;
    int                  assert_errors;
    int                  cycles;
    int                  limit;
    bit                  last_batch;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    victim_cam_top DUT (
        .clk          (clk),
        .rst          (rst),
        .insert_head  (insert_head),
        .insert_empty (insert_empty),
        .insert_pop   (insert_pop),
        .clear_empty  (clear_empty),
        .clear_pop    (clear_pop),
        .lookup_head  (lookup_head),
        .lookup_empty (lookup_empty),
        .lookup_pop   (lookup_pop),
        .vpkt         (vpkt),
        .vpkt_wr      (vpkt_wr),
        .vpkt_full    (vpkt_full),
        .mem_req      (mem_req),
        .mem_req_wr   (mem_req_wr),
        .mem_req_full (mem_req_full)
    );

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(string what);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic add_row(op_e kind, req_pkg::line_addr_t addr, req_pkg::seq_t seq,
                           int hold, bit batch);
        row_t r;
        r.kind  = kind;
        r.addr  = addr;
        r.seq   = seq;
        r.hold  = hold;
        r.batch = batch;
        table_q.push_back(r);
    endtask

    // ************************************************************
    // reference model, applied in table order
    // ************************************************************
    task automatic apply_model(row_t r);
        req_pkg::vpkt_t    v;
        req_pkg::mem_req_t m;
        m = '{seq: r.seq, addr: r.addr, wr: (r.kind == op_insert)};
        case (r.kind)
            op_insert: begin
                ref_slot.push_back(next_slot);
                ref_addr.push_back(r.addr);
                next_slot = (next_slot + 1) % 16;
                ins_q.push_back(m);
            end
            op_clear: begin
                void'(ref_slot.pop_front());
                void'(ref_addr.pop_front());
                clr_cnt++;
            end
            default: begin
                v = '{seq: r.seq, miss: 1'b1, slot: '0};
                // newest matching copy sits furthest back in the queue
                for (int i = 0; i < ref_addr.size(); i++) begin
                    if (ref_addr[i] == r.addr) begin
                        v.miss = 1'b0;
                        v.slot = cam_pkg::slot_t'(ref_slot[i]);
                    end
                end
                exp_vpkt.push_back(v);
                if (v.miss) begin
                    exp_mem.push_back(m);
                end
                lk_q.push_back(m);
            end
        endcase
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (ins_q.size() != 0 || lk_q.size() != 0 || clr_cnt != 0 ||
                   exp_vpkt.size() != 0 || exp_mem.size() != 0 ||
                   DUT.u_ctrl.state != cam_pkg::st_idle);
    endtask

    // upstream FIFO models, heads change just after the edge that ends a pop cycle
    always @(posedge clk) begin
        #1;
        if (pend_ins) begin
            if (ins_q.size() == 0) report_problem("insert pop from an empty FIFO");
            else void'(ins_q.pop_front());
        end
        if (pend_lk) begin
            if (lk_q.size() == 0) report_problem("lookup pop from an empty FIFO");
            else void'(lk_q.pop_front());
        end
        if (pend_clr) begin
            if (clr_cnt == 0) report_problem("clear pop from an empty FIFO");
            else clr_cnt--;
        end
        insert_empty = (ins_q.size() == 0);
        insert_head  = insert_empty ? '0 : ins_q[0];
        lookup_empty = (lk_q.size() == 0);
        lookup_head  = lookup_empty ? '0 : lk_q[0];
        clear_empty  = (clr_cnt == 0);
    end

    // ************************************************************
    // output monitor and timeout
    // ************************************************************
    always @(negedge clk) begin
        pend_ins = insert_pop;
        pend_clr = clear_pop;
        pend_lk  = lookup_pop;
        cycles++;
        if (!rst && vpkt_wr) begin
            if (mem_req_full) report_problem("vpkt written while mem_req_full was high");
            if (exp_vpkt.size() == 0) begin
                report_problem("unexpected vpkt write");
            end else begin
                check_value("vpkt", 64'(vpkt), 64'(exp_vpkt.pop_front()));
            end
        end
        if (!rst && mem_req_wr) begin
            if (exp_mem.size() == 0) begin
                report_problem("unexpected mem_req write");
            end else begin
                check_value("mem_req", 64'(mem_req), 64'(exp_mem.pop_front()));
            end
        end
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped serving requests", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        insert_head   = '0;
        insert_empty  = 1'b1;
        clear_empty   = 1'b1;
        lookup_head   = '0;
        lookup_empty  = 1'b1;
        vpkt_full     = 1'b0;
        mem_req_full  = 1'b0;
        pend_ins      = 1'b0;
        pend_clr      = 1'b0;
        pend_lk       = 1'b0;
        clr_cnt       = 0;
        next_slot     = 0;
        value_errors  = 0;
        other_errors  = 0;
        assert_errors = 0;
        cycles        = 0;
        limit         = 0;
        last_batch    = 1'b0;
        seed          = 25;

        // low bits carry the index so every address is distinct
        for (int i = 0; i < 20; i++) begin
            pool[i] = {21'($random(seed)), 5'(i)};
        end

        add_row(op_lookup, pool[0], 8'd1, 0, 0);           // empty buffer miss
        for (int i = 0; i < 4; i++) add_row(op_insert, pool[i], 8'(2 + i), 0, 0);
        add_row(op_lookup, pool[2], 8'd6, 0, 0);           // hit slot 2
        add_row(op_insert, pool[1], 8'd7, 0, 0);           // second copy in slot 4
        add_row(op_lookup, pool[1], 8'd8, 0, 0);
        add_row(op_clear, '0, '0, 0, 0);
        add_row(op_clear, '0, '0, 0, 0);
        add_row(op_lookup, pool[0], 8'd9, 0, 0);           // released
        add_row(op_lookup, pool[1], 8'd10, 0, 0);
        add_row(op_lookup, pool[3], 8'd11, 0, 0);
        // fill to 16 entries, wrapping past slot 15
        for (int i = 4; i < 17; i++) add_row(op_insert, pool[i], 8'(8 + i), 0, 0);
        add_row(op_lookup, pool[16], 8'd30, 0, 0);
        for (int i = 0; i < 3; i++) add_row(op_clear, '0, '0, 0, 0);
        add_row(op_lookup, pool[1], 8'd31, 0, 0);
        // lookup with the lower sequence number is served first
        add_row(op_lookup, pool[17], 8'd40, 0, 1);
        add_row(op_insert, pool[17], 8'd41, 0, 0);
        add_row(op_insert, pool[18], 8'd42, 0, 1);
        add_row(op_lookup, pool[18], 8'd43, 0, 0);
        // back-pressure on a hit and on a miss
        add_row(op_lookup, pool[9], 8'd44, 20, 0);
        add_row(op_lookup, pool[19], 8'd45, 10, 0);

        limit = 60 * table_q.size();
        @(negedge rst);

        foreach (table_q[i]) begin
            // a batch row shares its push cycle with the row after it
            if (!last_batch) @(posedge clk);
            last_batch = table_q[i].batch;
            apply_model(table_q[i]);
            if (table_q[i].hold > 0) begin
                #1 mem_req_full = 1'b1;
                repeat (table_q[i].hold) @(posedge clk);
                if (lk_q.size() != 1) report_problem("lookup left the FIFO while full was high");
                #1 mem_req_full = 1'b0;
            end
            if (!table_q[i].batch) wait_done();
        end

        repeat (5) @(negedge clk);
        assert_errors = DUT.u_ctrl.u_assert.fail_count;
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* victim_cam_top.f */
logic/cam_pkg.sv
logic/req_pkg.sv
logic/cam_occupancy.sv
logic/cam_scan_counter.sv
logic/cam_entry_ram.sv
logic/cam_match_unit.sv
logic/cam_ctrl_fsm.sv
logic/victim_cam_top.sv
verif/tb_clock_gen.sv
verif/victim_cam_assert.sv
verif/victim_cam_tb.sv

/* Makefile */
TOP = victim_cam_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f victim_cam_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f victim_cam_top.f --top-module $(TOP) -o vsim
	./obj_dir/vsim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
